/* logic/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define FETCH_ADDR_WIDTH 32

// 16 BTB entries
`define BTB_INDEX_BITS 4
`define RAS_DEPTH 4

`define RESET_PC 32'h0000_0000
`define NOP_INSTR 32'h0000_0013  // addi x0, x0, 0

// No compressed instructions, so every step is one word
`define INSTR_BYTES 32'd4

`endif

/* logic/fetch_types_pkg.sv */
`include "fetch_consts.svh"

package fetch_types_pkg;

  typedef logic [`FETCH_ADDR_WIDTH-1:0] addr_t;
  typedef logic [31:0] instr_t;

  typedef struct packed {
    addr_t pc;
    instr_t instr;
    logic taken;  // Successor pc came from a taken prediction
  } fetch_out_t;

  typedef struct packed {
    logic trap;
    logic mret;
    addr_t mtvec;
    addr_t mepc;
  } trap_ctrl_t;

  // Outcome of a control transfer, as seen in execute
  typedef struct packed {
    logic valid;
    addr_t pc;
    logic taken;
    addr_t target;
    logic predicted;  // Fetch predicted it taken
    logic is_branch;
    logic is_call;
    logic is_return;
  } resolve_t;

  typedef struct packed {
    addr_t pc;
  } bp_query_t;

  typedef struct packed {
    logic hit;
    logic taken;
    addr_t target;  // Already the stack top for a return
    logic uses_ras;
  } bp_answer_t;

endpackage

/* logic/bus_types_pkg.sv */
`include "fetch_consts.svh"

package bus_types_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

  // arprot[2:0] as defined by AXI
  typedef struct packed {
    logic instr;
    logic nonsecure;
    logic privileged;
  } axi_prot_t;

  typedef struct packed {
    logic [`FETCH_ADDR_WIDTH-1:0] araddr;
    axi_prot_t arprot;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] rdata;
    axi_resp_t rresp;
  } axi_r_t;

  typedef struct packed {
    logic [`FETCH_ADDR_WIDTH-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic error;
  } fetch_rsp_t;

endpackage

/* logic/branch_predictor.sv */
`include "fetch_consts.svh"

module branch_predictor
  import fetch_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input bp_query_t bp_query,
  output bp_answer_t bp_answer,
  input resolve_t resolve
);

  localparam int unsigned ENTRIES = 1 << `BTB_INDEX_BITS;
  localparam int unsigned TAG_BITS = `FETCH_ADDR_WIDTH - `BTB_INDEX_BITS - 2;
  localparam int unsigned SP_BITS = $clog2(`RAS_DEPTH);
  localparam logic [SP_BITS:0] RAS_FULL = `RAS_DEPTH;

  logic [ENTRIES-1:0] btb_valid;
  logic [TAG_BITS-1:0] btb_tag [ENTRIES];
  addr_t btb_target [ENTRIES];
  logic [1:0] btb_ctr [ENTRIES];
  logic btb_return [ENTRIES];

  addr_t ras [`RAS_DEPTH];
  logic [SP_BITS-1:0] ras_sp;  // Next free slot
  logic [SP_BITS:0] ras_count;

  logic [`BTB_INDEX_BITS-1:0] q_index, u_index;
  logic [TAG_BITS-1:0] q_tag, u_tag;
  logic q_hit, u_hit, train, ras_live, uses_ras;
  logic [1:0] u_ctr_base, u_ctr_next;
  addr_t ras_top;

  always_comb begin
    q_index = bp_query.pc[`BTB_INDEX_BITS+1:2];
    q_tag = bp_query.pc[`FETCH_ADDR_WIDTH-1:`BTB_INDEX_BITS+2];
    q_hit = btb_valid[q_index] && (btb_tag[q_index] == q_tag);
    ras_live = (ras_count != '0);
    ras_top = ras[ras_sp - 1'b1];
    uses_ras = q_hit && btb_return[q_index] && ras_live;

    bp_answer.hit = q_hit;
    bp_answer.taken = q_hit && btb_ctr[q_index][1];  // 10 and 11 predict taken
    bp_answer.uses_ras = uses_ras;
    bp_answer.target = uses_ras ? ras_top : btb_target[q_index];
  end

  always_comb begin
    u_index = resolve.pc[`BTB_INDEX_BITS+1:2];
    u_tag = resolve.pc[`FETCH_ADDR_WIDTH-1:`BTB_INDEX_BITS+2];
    u_hit = btb_valid[u_index] && (btb_tag[u_index] == u_tag);
    train = resolve.valid && (resolve.is_branch || resolve.is_call || resolve.is_return);

    u_ctr_base = u_hit ? btb_ctr[u_index] : 2'b01;  // New entry starts weakly not-taken
    if (resolve.taken) begin
      u_ctr_next = (u_ctr_base == 2'b11) ? 2'b11 : u_ctr_base + 2'd1;
    end else begin
      u_ctr_next = (u_ctr_base == 2'b00) ? 2'b00 : u_ctr_base - 2'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      btb_valid <= '0;
      ras_sp <= '0;
      ras_count <= '0;
    end else begin
      if (train) begin
        btb_valid[u_index] <= 1'b1;
      end
      if (resolve.valid && resolve.is_call) begin
        ras_sp <= ras_sp + 1'b1;  // Oldest entry is overwritten when full
        if (ras_count != RAS_FULL) begin
          ras_count <= ras_count + 1'b1;
        end
      end else if (resolve.valid && resolve.is_return && ras_live) begin
        ras_sp <= ras_sp - 1'b1;
        ras_count <= ras_count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (train) begin
      btb_tag[u_index] <= u_tag;
      btb_ctr[u_index] <= u_ctr_next;
      btb_return[u_index] <= resolve.is_return;
      if (resolve.taken || !u_hit) begin
        btb_target[u_index] <= resolve.target;
      end
    end
    if (resolve.valid && resolve.is_call) begin
      ras[ras_sp] <= resolve.pc + `INSTR_BYTES;
    end
  end

endmodule

/* logic/fetch_buffer.sv */
`include "fetch_consts.svh"

module fetch_buffer
  import bus_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input fetch_req_t fetch_req,
  input logic req_valid,
  output logic req_ready,
  output fetch_rsp_t fetch_rsp,
  output logic rsp_valid,
  input logic rsp_ready,
  input logic flush,
  output axi_ar_t ar,
  output logic arvalid,
  input logic arready,
  input axi_r_t r,
  input logic rvalid,
  output logic rready
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_t;

  state_t state;
  logic stale;  // Outstanding read belongs to a flushed path
  logic rsp_valid_q;
  axi_ar_t ar_q;
  fetch_rsp_t rsp_q;

  assign req_ready = (state == IDLE) && !rsp_valid_q;
  assign arvalid = (state == ADDR);
  assign rready = (state == DATA);
  assign ar = ar_q;
  assign rsp_valid = rsp_valid_q;
  assign fetch_rsp = rsp_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= IDLE;
      stale <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (rsp_valid_q && (rsp_ready || flush)) begin
        rsp_valid_q <= 1'b0;  // Taken, or dropped by a redirect
      end
      case (state)
        IDLE: begin
          if (req_valid && req_ready) begin
            state <= ADDR;
            stale <= flush;
          end
        end
        ADDR: begin
          if (flush) begin
            stale <= 1'b1;
          end
          if (arready) begin
            state <= DATA;
          end
        end
        DATA: begin
          if (rvalid) begin
            state <= IDLE;
            stale <= 1'b0;
            rsp_valid_q <= !(stale || flush);
          end else if (flush) begin
            stale <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      ar_q.araddr <= fetch_req.addr;
      ar_q.arprot <= '{instr: 1'b1, nonsecure: 1'b0, privileged: 1'b1};
    end
    if (rvalid && rready) begin
      rsp_q.rdata <= r.rdata;
      rsp_q.error <= (r.rresp != RESP_OKAY);
    end
  end

endmodule

/* logic/fetch_stage.sv */
`include "fetch_consts.svh"

module fetch_stage
  import fetch_types_pkg::*;
  import bus_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input trap_ctrl_t trap_ctrl,
  input resolve_t resolve,
  output bp_query_t bp_query,
  input bp_answer_t bp_answer,
  output fetch_req_t fetch_req,
  output logic req_valid,
  input logic req_ready,
  input fetch_rsp_t fetch_rsp,
  input logic rsp_valid,
  output logic rsp_ready,
  output logic flush,
  output fetch_out_t fetch_out,
  output logic out_valid,
  input logic out_ready
);

  addr_t pc;  // Address of the next request
  logic issue;  // Request pending toward the buffer
  logic waiting;  // Read accepted, word not yet taken

  addr_t inflight_pc;
  logic inflight_taken;

  // Last taken prediction, used to check a resolved target
  logic pred_valid;
  addr_t pred_pc;
  addr_t pred_target;

  fetch_out_t out_q;
  logic out_valid_q;

  logic predict_taken, mispredict, redirect;
  addr_t next_pc, redirect_pc;

  always_comb begin
    predict_taken = bp_answer.hit && bp_answer.taken;
    next_pc = predict_taken ? bp_answer.target : pc + `INSTR_BYTES;

    mispredict = 1'b0;
    if (resolve.valid) begin
      if (resolve.taken != resolve.predicted) begin
        mispredict = 1'b1;
      end else if (resolve.taken &&
                   !(pred_valid && pred_pc == resolve.pc && pred_target == resolve.target)) begin
        mispredict = 1'b1;  // Right direction, wrong target
      end
    end

    redirect = trap_ctrl.trap || trap_ctrl.mret || mispredict;
    if (trap_ctrl.trap) begin
      redirect_pc = trap_ctrl.mtvec;
    end else if (trap_ctrl.mret) begin
      redirect_pc = trap_ctrl.mepc;
    end else if (resolve.taken) begin
      redirect_pc = resolve.target;
    end else begin
      redirect_pc = resolve.pc + `INSTR_BYTES;
    end
  end

  assign bp_query.pc = pc;
  assign fetch_req.addr = pc;
  assign req_valid = issue && !redirect;
  assign rsp_ready = waiting && (!out_valid_q || out_ready);
  assign flush = redirect;
  assign fetch_out = out_q;
  assign out_valid = out_valid_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= `RESET_PC;
      issue <= 1'b1;
      waiting <= 1'b0;
      pred_valid <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      // A word already offered to decode stays until taken
      if (out_valid_q && out_ready) begin
        out_valid_q <= 1'b0;
      end
      if (redirect) begin
        pc <= redirect_pc;
        issue <= 1'b1;
        waiting <= 1'b0;
      end else begin
        if (req_valid && req_ready) begin
          pc <= next_pc;
          issue <= 1'b0;
          waiting <= 1'b1;
          if (predict_taken) begin
            pred_valid <= 1'b1;
          end
        end
        if (rsp_valid && rsp_ready) begin
          waiting <= 1'b0;
          issue <= 1'b1;
          out_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      inflight_pc <= pc;
      inflight_taken <= predict_taken;
      if (predict_taken) begin
        pred_pc <= pc;
        pred_target <= bp_answer.target;
      end
    end
    if (rsp_valid && rsp_ready && !redirect) begin
      out_q.pc <= inflight_pc;
      out_q.instr <= fetch_rsp.error ? `NOP_INSTR : fetch_rsp.rdata;
      out_q.taken <= inflight_taken;
    end
  end

endmodule

/* logic/fetch_unit.sv */
module fetch_unit
  import fetch_types_pkg::*;
  import bus_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input trap_ctrl_t trap_ctrl,
  input resolve_t resolve,
  output axi_ar_t ar,
  output logic arvalid,
  input logic arready,
  input axi_r_t r,
  input logic rvalid,
  output logic rready,
  output fetch_out_t fetch_out,
  output logic out_valid,
  input logic out_ready
);

  bp_query_t bp_query;
  bp_answer_t bp_answer;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  logic req_valid, req_ready;
  logic rsp_valid, rsp_ready;
  logic flush;

  fetch_stage stage (
    .clock(clock),
    .reset(reset),
    .trap_ctrl(trap_ctrl),
    .resolve(resolve),
    .bp_query(bp_query),
    .bp_answer(bp_answer),
    .fetch_req(fetch_req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .fetch_rsp(fetch_rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .flush(flush),
    .fetch_out(fetch_out),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  branch_predictor predictor (
    .clock(clock),
    .reset(reset),
    .bp_query(bp_query),
    .bp_answer(bp_answer),
    .resolve(resolve)  // Trained straight from execute
  );

  fetch_buffer buffer (
    .clock(clock),
    .reset(reset),
    .fetch_req(fetch_req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .fetch_rsp(fetch_rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .flush(flush),
    .ar(ar),
    .arvalid(arvalid),
    .arready(arready),
    .r(r),
    .rvalid(rvalid),
    .rready(rready)
  );

endmodule

/* testbench/fetch_unit_properties.sv */
module fetch_unit_properties
  import fetch_types_pkg::*;
  import bus_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input axi_ar_t ar,
  input logic arvalid,
  input logic arready,
  input fetch_out_t fetch_out,
  input logic out_valid,
  input logic out_ready
);

  int unsigned fails = 0;

  ar_hold: assert property (@(posedge clock) disable iff (!reset)
    arvalid && !arready |=> arvalid && $stable(ar))
  else begin
    fails++;
    $error("arvalid dropped or ar changed before arready");
  end

  out_hold: assert property (@(posedge clock) disable iff (!reset)
    out_valid && !out_ready |=> out_valid && $stable(fetch_out))
  else begin
    fails++;
    $error("out_valid dropped or fetch_out changed while decode stalled");
  end

  reset_quiet: assert property (@(posedge clock) $rose(reset) |-> !out_valid && !arvalid)
  else begin
    fails++;
    $error("out_valid or arvalid active when reset was released");
  end

endmodule

bind fetch_unit fetch_unit_properties props (
  .clock(clock),
  .reset(reset),
  .ar(ar),
  .arvalid(arvalid),
  .arready(arready),
  .fetch_out(fetch_out),
  .out_valid(out_valid),
  .out_ready(out_ready)
);

/* testbench/tb_clock.sv */
module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Held low for the first three rising edges
  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

/* testbench/tb_fetch_unit.sv */
`include "fetch_consts.svh"

module tb_fetch_unit
  import fetch_types_pkg::*;
  import bus_types_pkg::*;
();

  localparam addr_t ERR_ADDR = 32'h0000_0308;  // Answered with SLVERR
  localparam int ENTRIES = 1 << `BTB_INDEX_BITS;

  logic clock, reset;
  trap_ctrl_t trap_ctrl;
  resolve_t resolve;
  axi_ar_t ar;
  logic arvalid, arready;
  axi_r_t r;
  logic rvalid, rready;
  fetch_out_t fetch_out;
  logic out_valid, out_ready;

  integer seed = 32'h474d;
  logic [31:0] mem [256];
  addr_t rd_addr;
  int ar_delay, r_delay;
  logic r_pend;

  // Predictor model
  logic m_valid [ENTRIES];
  addr_t m_tag [ENTRIES];
  addr_t m_target [ENTRIES];
  logic [1:0] m_ctr [ENTRIES];
  logic m_ret [ENTRIES];
  addr_t m_ras [`RAS_DEPTH];
  int m_sp, m_count;

  addr_t exp_pc, ar_next, ar_redirect_pc;
  logic ar_redirect_pending, random_ready, held_valid, read_open;
  fetch_out_t held_out;
  int errors, words, ar_count, stall_cycles, predicted_words;

  tb_clock clocks (
    .clock(clock),
    .reset(reset)
  );

  fetch_unit DUT (
    .clock(clock),
    .reset(reset),
    .trap_ctrl(trap_ctrl),
    .resolve(resolve),
    .ar(ar),
    .arvalid(arvalid),
    .arready(arready),
    .r(r),
    .rvalid(rvalid),
    .rready(rready),
    .fetch_out(fetch_out),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  // Instruction memory with random handshake delays
  always @(posedge clock) begin
    if (!reset) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      r_pend <= 1'b0;
      ar_delay <= 0;
    end else begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        rd_addr <= ar.araddr;
        r_pend <= 1'b1;
        r_delay <= $random(seed) & 3;
        ar_delay <= $random(seed) & 3;
      end else if (arvalid) begin
        if (ar_delay == 0) begin
          arready <= 1'b1;
        end else begin
          ar_delay <= ar_delay - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_pend <= 1'b0;
      end else if (r_pend && !rvalid) begin
        if (r_delay == 0) begin
          rvalid <= 1'b1;
          r.rdata <= mem[rd_addr[9:2]];
          r.rresp <= (rd_addr == ERR_ADDR) ? RESP_SLVERR : RESP_OKAY;
        end else begin
          r_delay <= r_delay - 1;
        end
      end
    end
  end

  function automatic logic [31:0] expected_instr(addr_t pc);
    return (pc == ERR_ADDR) ? `NOP_INSTR : mem[pc[9:2]];
  endfunction

  function automatic bp_answer_t model_answer(addr_t pc);
    bp_answer_t ans;
    int idx;
    idx = pc[`BTB_INDEX_BITS+1:2];
    ans.hit = m_valid[idx] && (m_tag[idx] == (pc >> (`BTB_INDEX_BITS + 2)));
    ans.taken = ans.hit && (m_ctr[idx] >= 2'b10);
    ans.uses_ras = ans.hit && m_ret[idx] && (m_count > 0);
    ans.target = ans.uses_ras ? m_ras[(m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH] : m_target[idx];
    return ans;
  endfunction

  function automatic addr_t model_next(addr_t pc);
    bp_answer_t ans;
    ans = model_answer(pc);
    return ans.taken ? ans.target : pc + 32'd4;
  endfunction

  task automatic model_train(input resolve_t res);
    int idx;
    logic hit;
    logic [1:0] ctr;
    idx = res.pc[`BTB_INDEX_BITS+1:2];
    hit = m_valid[idx] && (m_tag[idx] == (res.pc >> (`BTB_INDEX_BITS + 2)));
    if (res.valid && (res.is_branch || res.is_call || res.is_return)) begin
      ctr = hit ? m_ctr[idx] : 2'b01;
      if (res.taken && ctr != 2'b11) begin
        ctr = ctr + 2'd1;
      end else if (!res.taken && ctr != 2'b00) begin
        ctr = ctr - 2'd1;
      end
      if (res.taken || !hit) begin
        m_target[idx] = res.target;
      end
      m_valid[idx] = 1'b1;
      m_tag[idx] = res.pc >> (`BTB_INDEX_BITS + 2);
      m_ctr[idx] = ctr;
      m_ret[idx] = res.is_return;
    end
    if (res.valid && res.is_call) begin
      m_ras[m_sp] = res.pc + 32'd4;
      m_sp = (m_sp + 1) % `RAS_DEPTH;
      if (m_count < `RAS_DEPTH) begin
        m_count++;
      end
    end else if (res.valid && res.is_return && m_count > 0) begin
      m_sp = (m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH;
      m_count--;
    end
  endtask

  task automatic check_fetch_out(input fetch_out_t want, input fetch_out_t got);
    if (got !== want) begin
      errors++;
      $display("ERROR at time %0t: fetch_out pc %h instr %h taken %b, expected %h %h %b",
               $time, got.pc, got.instr, got.taken, want.pc, want.instr, want.taken);
    end
  endtask

  task automatic check_axi_ar(input axi_ar_t want, input axi_ar_t got);
    if (got !== want) begin
      errors++;
      $display("ERROR at time %0t: ar addr %h prot %b, expected %h %b",
               $time, got.araddr, got.arprot, want.araddr, want.arprot);
    end
  endtask

  // Checks one clock edge and drives the next cycle
  task automatic step();
    fetch_out_t want;
    axi_ar_t want_ar;
    bp_answer_t ans;
    @(posedge clock);
    trap_ctrl <= '0;
    resolve <= '0;
    if (held_valid) begin
      stall_cycles++;
      if (!out_valid) begin
        errors++;
        $display("out_valid dropped at time %0t while decode was stalled", $time);
      end else begin
        check_fetch_out(held_out, fetch_out);
      end
    end
    held_valid = out_valid && !out_ready;
    held_out = fetch_out;
    // Only a read waiting for its data keeps rready high
    if (rready !== read_open) begin
      errors++;
      $display("ERROR at time %0t: rready %b, expected %b", $time, rready, read_open);
    end
    if (rvalid && rready) begin
      read_open = 1'b0;
    end
    if (arvalid && arready) begin
      want_ar.araddr = ar_next;
      want_ar.arprot = '{instr: 1'b1, nonsecure: 1'b0, privileged: 1'b1};  // Machine-mode fetch
      check_axi_ar(want_ar, ar);
      ar_count++;
      read_open = 1'b1;
      ar_next = ar_redirect_pending ? ar_redirect_pc : model_next(ar_next);
      ar_redirect_pending = 1'b0;
    end
    if (out_valid && out_ready) begin
      ans = model_answer(exp_pc);
      want.pc = exp_pc;
      want.instr = expected_instr(exp_pc);
      want.taken = ans.taken;
      check_fetch_out(want, fetch_out);
      if (fetch_out.taken) begin
        predicted_words++;
      end
      exp_pc = model_next(exp_pc);
      words++;
    end
    out_ready <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic wait_words(input int n, input string what);
    int target;
    int cycles;
    target = words + n;
    cycles = 0;
    while (words < target && cycles < 50 * n) begin
      step();
      cycles++;
    end
    if (words < target) begin
      errors++;
      $display("Timeout: decode got no word within %0d cycles during %s", 50 * n, what);
    end
  endtask

  function automatic trap_ctrl_t trap_pulse(logic trap, logic mret, addr_t mtvec, addr_t mepc);
    trap_ctrl_t t;
    t.trap = trap;
    t.mret = mret;
    t.mtvec = mtvec;
    t.mepc = mepc;
    return t;
  endfunction

  // kind is {is_branch, is_call, is_return}
  function automatic resolve_t outcome(addr_t pc, logic taken, addr_t target, logic predicted,
                                       logic [2:0] kind);
    resolve_t res;
    res.valid = 1'b1;
    res.pc = pc;
    res.taken = taken;
    res.target = target;
    res.predicted = predicted;
    {res.is_branch, res.is_call, res.is_return} = kind;
    return res;
  endfunction

  // Applied right after a word is taken, with decode always ready
  task automatic redirect(input trap_ctrl_t t, input resolve_t res);
    addr_t target;
    wait_words(1, "redirect sync");
    if (t.trap) begin
      target = t.mtvec;
    end else if (t.mret) begin
      target = t.mepc;
    end else if (res.taken) begin
      target = res.target;
    end else begin
      target = res.pc + 32'd4;
    end
    trap_ctrl <= t;
    resolve <= res;
    model_train(res);
    exp_pc = target;
    ar_redirect_pending = 1'b1;  // The flushed read still shows on the bus first
    ar_redirect_pc = target;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s: %s, %0d errors", name, (errors == errors_before) ? "ok" : "failed",
             errors - errors_before);
  endtask

  initial begin
    int start;
    int reset_cycles;
    trap_ctrl = '0;
    resolve = '0;
    out_ready = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    r = '0;
    random_ready = 1'b1;
    held_valid = 1'b0;
    read_open = 1'b0;
    errors = 0;
    words = 0;
    ar_count = 0;
    stall_cycles = 0;
    predicted_words = 0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
    m_sp = 0;
    m_count = 0;
    exp_pc = `RESET_PC;
    ar_next = `RESET_PC;
    ar_redirect_pending = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $random(seed);
    end

    reset_cycles = 0;
    while (reset !== 1'b1 && reset_cycles < 10) begin
      @(posedge clock);
      reset_cycles++;
    end
    if (reset !== 1'b1) begin
      errors++;
      $display("Timeout: reset was never released");
    end

    start = errors;
    wait_words(12, "sequential fetch");
    report_test("sequential fetch", start);

    start = errors;
    random_ready = 1'b0;
    wait_words(2, "settling");
    redirect(trap_pulse(1'b1, 1'b0, 32'h100, 32'h0), '0);
    wait_words(4, "trap");
    redirect(trap_pulse(1'b0, 1'b1, 32'h0, 32'h180), '0);
    wait_words(4, "mret");
    redirect(trap_pulse(1'b1, 1'b1, 32'h140, 32'h1c0), '0);  // Trap wins
    wait_words(4, "trap with mret");
    report_test("trap and return", start);

    start = errors;
    redirect('0, outcome(32'h200, 1'b1, 32'h240, 1'b0, 3'b100));
    wait_words(4, "taken mispredict");
    redirect('0, outcome(32'h260, 1'b0, 32'h280, 1'b1, 3'b100));
    wait_words(4, "not-taken mispredict");
    report_test("mispredict correction", start);

    start = errors;
    predicted_words = 0;
    redirect('0, outcome(32'h2a8, 1'b1, 32'h2e0, 1'b0, 3'b100));
    wait_words(2, "branch training");
    redirect('0, outcome(32'h2a8, 1'b1, 32'h2e0, 1'b0, 3'b100));
    wait_words(2, "branch training");
    redirect(trap_pulse(1'b1, 1'b0, 32'h2a0, 32'h0), '0);
    wait_words(4, "predicted branch");
    redirect('0, outcome(32'h314, 1'b1, 32'h380, 1'b0, 3'b010));
    wait_words(2, "first call");
    redirect('0, outcome(32'h3b0, 1'b1, 32'h318, 1'b0, 3'b001));
    wait_words(2, "return");
    redirect('0, outcome(32'h33c, 1'b1, 32'h3a8, 1'b0, 3'b010));
    wait_words(4, "predicted return");
    if (predicted_words < 2) begin
      errors++;
      $display("Prediction test delivered only %0d predicted-taken words", predicted_words);
    end
    report_test("prediction", start);

    start = errors;
    redirect(trap_pulse(1'b1, 1'b0, 32'h300, 32'h0), '0);
    random_ready = 1'b1;
    reset_cycles = stall_cycles;
    wait_words(16, "back-pressure and bus error");
    if (stall_cycles == reset_cycles) begin
      errors++;
      $display("Decode was never stalled during the back-pressure test");
    end
    report_test("back-pressure and bus error", start);

    $display("Summary: %0d words, %0d reads, %0d stall cycles, %0d errors, %0d assertion failures",
             words, ar_count, stall_cycles, errors, DUT.props.fails);
    if (errors == 0 && DUT.props.fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* fetch_unit.f */
+incdir+logic
logic/fetch_types_pkg.sv
logic/bus_types_pkg.sv
logic/branch_predictor.sv
logic/fetch_buffer.sv
logic/fetch_stage.sv
logic/fetch_unit.sv
testbench/fetch_unit_properties.sv
testbench/tb_clock.sv
testbench/tb_fetch_unit.sv
